/* decode_pkg.sv */
package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // decoded instruction set of this stage
    typedef enum logic [5:0] {
        op_invalid,
        op_add_w,
        op_sub_w,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_sll_w,
        op_srl_w,
        op_sra_w,
        op_addi_w,
        op_slti,
        op_sltui,
        op_andi,
        op_ori,
        op_xori,
        op_slli_w,
        op_srli_w,
        op_srai_w,
        op_lu12i_w,
        op_pcaddu12i,
        op_ld_w,
        op_st_w,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_b,
        op_bl,
        op_jirl
    } op_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_nor,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef struct packed {
        logic [xlen-1:0] inst;
        logic [xlen-1:0] pc;
    } fetch_bus_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } rf_write_t;

    // dest 0 means nothing pending in that stage
    typedef struct packed {
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       value;
        logic                  from_mem;
    } fwd_src_t;

    typedef struct packed {
        op_e                   op;
        alu_op_e               alu_op;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] raddr2;
        logic                  use_rj;
        logic                  use_r2;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       br_offs;
        logic [reg_addr_w-1:0] dest;
        logic                  gr_we;
        logic                  mem_we;
        logic                  res_from_mem;
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0] rj_value;
        logic [xlen-1:0] rkd_value;
    } operands_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } branch_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        logic [xlen-1:0]       alu_src1;
        logic [xlen-1:0]       alu_src2;
        logic [xlen-1:0]       st_data;
        logic                  res_from_mem;
        logic                  mem_we;
        logic [reg_addr_w-1:0] dest;
        logic                  gr_we;
    } exec_bus_t;

endpackage

/* inst_decoder.sv */
module inst_decoder (
    input  logic [31:0]          inst,
    output decode_pkg::decoded_t dec
);
    import decode_pkg::*;

    op_e                   op;
    logic [5:0]            op_31_26;
    logic [3:0]            op_25_22;
    logic [1:0]            op_21_20;
    logic [4:0]            op_19_15;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rj;
    logic [reg_addr_w-1:0] rk;
    logic [11:0]           i12;
    logic [15:0]           i16;
    logic [19:0]           i20;
    logic [25:0]           i26;
    logic                  is_cond_br;
    logic                  is_3r;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    // offs26 keeps its high half in the rd/rj fields
    assign i26 = {inst[9:0], inst[25:10]};

    always_comb begin
        op = op_invalid;
        case (op_31_26)
            6'h00: begin
                case (op_25_22)
                    4'h0: begin
                        if (op_21_20 == 2'h1) begin
                            case (op_19_15)
                                5'h00:   op = op_add_w;
                                5'h02:   op = op_sub_w;
                                5'h04:   op = op_slt;
                                5'h05:   op = op_sltu;
                                5'h08:   op = op_nor;
                                5'h09:   op = op_and;
                                5'h0a:   op = op_or;
                                5'h0b:   op = op_xor;
                                5'h0e:   op = op_sll_w;
                                5'h0f:   op = op_srl_w;
                                5'h10:   op = op_sra_w;
                                default: op = op_invalid;
                            endcase
                        end
                    end
                    4'h1: begin
                        if (op_21_20 == 2'h0) begin
                            case (op_19_15)
                                5'h01:   op = op_slli_w;
                                5'h09:   op = op_srli_w;
                                5'h11:   op = op_srai_w;
                                default: op = op_invalid;
                            endcase
                        end
                    end
                    4'h8:    op = op_slti;
                    4'h9:    op = op_sltui;
                    4'ha:    op = op_addi_w;
                    4'hd:    op = op_andi;
                    4'he:    op = op_ori;
                    4'hf:    op = op_xori;
                    default: op = op_invalid;
                endcase
            end
            6'h05: op = inst[25] ? op_invalid : op_lu12i_w;
            6'h07: op = inst[25] ? op_invalid : op_pcaddu12i;
            6'h0a: begin
                if (op_25_22 == 4'h2) begin
                    op = op_ld_w;
                end else if (op_25_22 == 4'h6) begin
                    op = op_st_w;
                end
            end
            6'h13:   op = op_jirl;
            6'h14:   op = op_b;
            6'h15:   op = op_bl;
            6'h16:   op = op_beq;
            6'h17:   op = op_bne;
            6'h18:   op = op_blt;
            6'h19:   op = op_bge;
            6'h1a:   op = op_bltu;
            6'h1b:   op = op_bgeu;
            default: op = op_invalid;
        endcase
    end

    assign is_cond_br = op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    assign is_3r = op inside {op_add_w, op_sub_w, op_slt, op_sltu, op_and, op_or,
                              op_xor, op_nor, op_sll_w, op_srl_w, op_sra_w};

    always_comb begin
        dec    = '0;
        dec.op = op;
        case (op)
            op_sub_w:              dec.alu_op = alu_sub;
            op_slt, op_slti:       dec.alu_op = alu_slt;
            op_sltu, op_sltui:     dec.alu_op = alu_sltu;
            op_and, op_andi:       dec.alu_op = alu_and;
            op_or, op_ori:         dec.alu_op = alu_or;
            op_xor, op_xori:       dec.alu_op = alu_xor;
            op_nor:                dec.alu_op = alu_nor;
            op_sll_w, op_slli_w:   dec.alu_op = alu_sll;
            op_srl_w, op_srli_w:   dec.alu_op = alu_srl;
            op_sra_w, op_srai_w:   dec.alu_op = alu_sra;
            op_lu12i_w:            dec.alu_op = alu_lui;
            default:               dec.alu_op = alu_add;
        endcase

        dec.rj     = rj;
        dec.raddr2 = (is_cond_br || op == op_st_w) ? rd : rk;
        dec.use_rj = !(op inside {op_invalid, op_b, op_bl, op_lu12i_w, op_pcaddu12i});
        dec.use_r2 = is_3r || is_cond_br || op == op_st_w;

        dec.src1_is_pc  = op inside {op_jirl, op_bl, op_pcaddu12i};
        dec.src2_is_imm = op inside {op_addi_w, op_slti, op_sltui, op_andi, op_ori, op_xori,
                                     op_slli_w, op_srli_w, op_srai_w, op_lu12i_w,
                                     op_pcaddu12i, op_ld_w, op_st_w, op_jirl, op_bl};

        // link value is pc + 4
        if (op inside {op_jirl, op_bl}) begin
            dec.imm = 32'd4;
        end else if (op inside {op_andi, op_ori, op_xori}) begin
            dec.imm = {20'h0, i12};
        end else if (op inside {op_lu12i_w, op_pcaddu12i}) begin
            dec.imm = {i20, 12'h0};
        end else begin
            dec.imm = {{20{i12[11]}}, i12};
        end

        if (op inside {op_b, op_bl}) begin
            dec.br_offs = {{4{i26[25]}}, i26, 2'b00};
        end else begin
            dec.br_offs = {{14{i16[15]}}, i16, 2'b00};
        end

        dec.dest         = (op == op_bl) ? 5'd1 : rd;
        dec.gr_we        = !(is_cond_br || op inside {op_st_w, op_b, op_invalid});
        dec.mem_we       = op == op_st_w;
        dec.res_from_mem = op == op_ld_w;
    end

endmodule

/* regfile.sv */
module regfile (
    input  logic                  clk,
    input  logic [4:0]            raddr1,
    input  logic [4:0]            raddr2,
    output logic [31:0]           rdata1,
    output logic [31:0]           rdata2,
    input  decode_pkg::rf_write_t wr
);
    import decode_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 always reads as zero even after a write
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* operand_bypass.sv */
module operand_bypass (
    input  decode_pkg::decoded_t  dec,
    input  logic [31:0]           rdata1,
    input  logic [31:0]           rdata2,
    input  decode_pkg::fwd_src_t  es_fwd,
    input  decode_pkg::fwd_src_t  ms_fwd,
    input  decode_pkg::fwd_src_t  ws_fwd,
    output decode_pkg::operands_t ops,
    output logic                  stall
);
    import decode_pkg::*;

    logic rj_hits_load;
    logic r2_hits_load;

    // youngest producer has priority over older stages
    function automatic logic [xlen-1:0] pick_value(
        input logic                  used,
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0]       rf_value,
        input fwd_src_t              es,
        input fwd_src_t              ms,
        input fwd_src_t              ws
    );
        logic [xlen-1:0] value;
        value = rf_value;
        if (used && addr != '0) begin
            if (addr == es.dest) begin
                value = es.value;
            end else if (addr == ms.dest) begin
                value = ms.value;
            end else if (addr == ws.dest) begin
                value = ws.value;
            end
        end
        return value;
    endfunction

    always_comb begin
        ops.rj_value  = pick_value(dec.use_rj, dec.rj, rdata1, es_fwd, ms_fwd, ws_fwd);
        ops.rkd_value = pick_value(dec.use_r2, dec.raddr2, rdata2, es_fwd, ms_fwd, ws_fwd);
    end

    // load in execute has no data yet
    assign rj_hits_load = dec.use_rj && dec.rj != '0 && dec.rj == es_fwd.dest;
    assign r2_hits_load = dec.use_r2 && dec.raddr2 != '0 && dec.raddr2 == es_fwd.dest;

    assign stall = es_fwd.from_mem && (rj_hits_load || r2_hits_load);

endmodule

/* branch_unit.sv */
module branch_unit (
    input  decode_pkg::decoded_t  dec,
    input  decode_pkg::operands_t ops,
    input  logic [31:0]           pc,
    output logic                  cond,
    output logic [31:0]           target
);
    import decode_pkg::*;

    logic            rj_eq_rd;
    logic            rj_lt_rd;
    logic            rj_ltu_rd;
    logic [xlen-1:0] base;

    assign rj_eq_rd  = ops.rj_value == ops.rkd_value;
    assign rj_lt_rd  = $signed(ops.rj_value) < $signed(ops.rkd_value);
    assign rj_ltu_rd = ops.rj_value < ops.rkd_value;

    always_comb begin
        case (dec.op)
            op_beq:                cond = rj_eq_rd;
            op_bne:                cond = !rj_eq_rd;
            op_blt:                cond = rj_lt_rd;
            op_bge:                cond = !rj_lt_rd;
            op_bltu:               cond = rj_ltu_rd;
            op_bgeu:               cond = !rj_ltu_rd;
            op_b, op_bl, op_jirl:  cond = 1'b1;
            default:               cond = 1'b0;
        endcase
    end

    // jirl is register relative and all others pc relative
    assign base   = (dec.op == op_jirl) ? ops.rj_value : pc;
    assign target = base + dec.br_offs;

endmodule

/* decode_stage.sv */
module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_valid,
    input  decode_pkg::fetch_bus_t fetch_bus,
    output logic                  ds_allowin,
    output logic                  es_valid,
    input  logic                  es_allowin,
    output decode_pkg::exec_bus_t exec_bus,
    output decode_pkg::branch_t   br,
    input  decode_pkg::rf_write_t rf_wr,
    input  decode_pkg::fwd_src_t  es_fwd,
    input  decode_pkg::fwd_src_t  ms_fwd,
    input  decode_pkg::fwd_src_t  ws_fwd,
    input  logic                  flush
);
    import decode_pkg::*;

    logic            ds_valid;
    fetch_bus_t      ds_bus;
    decoded_t        dec;
    logic [xlen-1:0] rf_rdata1;
    logic [xlen-1:0] rf_rdata2;
    operands_t       ops;
    logic            stall;
    logic            br_cond;
    logic [xlen-1:0] br_target;
    logic            issue;

    inst_decoder u_inst_decoder (
        .inst (ds_bus.inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.rj),
        .raddr2 (dec.raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (rf_wr)
    );

    operand_bypass u_operand_bypass (
        .dec    (dec),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .es_fwd (es_fwd),
        .ms_fwd (ms_fwd),
        .ws_fwd (ws_fwd),
        .ops    (ops),
        .stall  (stall)
    );

    branch_unit u_branch_unit (
        .dec    (dec),
        .ops    (ops),
        .pc     (ds_bus.pc),
        .cond   (br_cond),
        .target (br_target)
    );

    // flush kills the instruction in the same cycle
    assign es_valid   = ds_valid && !stall && !flush;
    assign issue      = es_valid && es_allowin;
    assign ds_allowin = !ds_valid || issue;

    assign br.taken  = br_cond && issue;
    assign br.target = br_target;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush || br.taken) begin
            // instruction fetched behind a taken branch is wrong path
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_bus <= fetch_bus;
        end
    end

    always_comb begin
        exec_bus.pc           = ds_bus.pc;
        exec_bus.alu_op       = dec.alu_op;
        exec_bus.alu_src1     = dec.src1_is_pc ? ds_bus.pc : ops.rj_value;
        exec_bus.alu_src2     = dec.src2_is_imm ? dec.imm : ops.rkd_value;
        // store data comes through the rd read port
        exec_bus.st_data      = ops.rkd_value;
        exec_bus.res_from_mem = dec.res_from_mem;
        exec_bus.mem_we       = dec.mem_we;
        exec_bus.dest         = dec.dest;
        exec_bus.gr_we        = dec.gr_we;
    end

endmodule

/* decode_assert.sv */
module decode_assert (
    input logic                  clk,
    input logic                  reset,
    input logic                  es_valid,
    input logic                  es_allowin,
    input decode_pkg::exec_bus_t exec_bus,
    input decode_pkg::branch_t   br
);
    import decode_pkg::*;

    // stage comes out of reset empty
    a_empty_after_reset: assert property (@(posedge clk) reset |=> !es_valid)
        else $error("es_valid high after reset");

    // wrong-path instruction behind a taken branch is dropped
    a_branch_cancels: assert property (@(posedge clk) disable iff (reset)
        br.taken |=> !es_valid)
        else $error("instruction issued right after a taken branch");

    // held instruction must not change under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        (es_valid && !es_allowin) |=> $stable(exec_bus))
        else $error("exec_bus changed while stalled by execute");

endmodule

bind decode_stage decode_assert u_decode_assert (
    .clk        (clk),
    .reset      (reset),
    .es_valid   (es_valid),
    .es_allowin (es_allowin),
    .exec_bus   (exec_bus),
    .br         (br)
);

/* tb_decode_stage.sv */
module tb_decode_stage;
    import decode_pkg::*;

    localparam int timeout_cycles = 20;

    logic        clk;
    logic        reset;
    logic        fs_valid;
    fetch_bus_t  fetch_bus;
    logic        ds_allowin;
    logic        es_valid;
    logic        es_allowin;
    exec_bus_t   exec_bus;
    branch_t     br;
    rf_write_t   rf_wr;
    fwd_src_t    es_fwd;
    fwd_src_t    ms_fwd;
    fwd_src_t    ws_fwd;
    logic        flush;
    logic [31:0] lfsr_state;
    logic [31:0] rf_model [32];
    logic [31:0] next_pc;

    decode_stage u_decode_stage (
        .clk        (clk),
        .reset      (reset),
        .fs_valid   (fs_valid),
        .fetch_bus  (fetch_bus),
        .ds_allowin (ds_allowin),
        .es_valid   (es_valid),
        .es_allowin (es_allowin),
        .exec_bus   (exec_bus),
        .br         (br),
        .rf_wr      (rf_wr),
        .es_fwd     (es_fwd),
        .ms_fwd     (ms_fwd),
        .ws_fwd     (ws_fwd),
        .flush      (flush)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'ha300_0000;
        end
        return s >> 1;
    endfunction

    task automatic next_rand(output logic [31:0] value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_exec(input string name, input exec_bus_t got, input exec_bus_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_branch(input string name, input branch_t got, input branch_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED t=%0t %s got=%b expected=%b", $time, name, got, exp));
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    function automatic logic [31:0] reg_val(input logic [4:0] a);
        return (a == 5'd0) ? 32'h0 : rf_model[a];
    endfunction

    function automatic logic [31:0] sext12(input logic [31:0] inst);
        return {{20{inst[21]}}, inst[21:10]};
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        rf_wr.we   = 1'b1;
        rf_wr.addr = addr;
        rf_wr.data = data;
        tick();
        rf_wr.we = 1'b0;
        rf_model[addr] = data;
    endtask

    task automatic set_fwd(input logic [4:0] ed, input logic [31:0] ev, input logic [4:0] md,
                           input logic [31:0] mv, input logic [4:0] wd, input logic [31:0] wv);
        es_fwd = '{dest: ed, value: ev, from_mem: 1'b0};
        ms_fwd = '{dest: md, value: mv, from_mem: 1'b0};
        ws_fwd = '{dest: wd, value: wv, from_mem: 1'b0};
    endtask

    // hold the fetch bus until the stage takes it
    task automatic send(input logic [31:0] inst, input logic [31:0] pc);
        int n;
        n = 0;
        fetch_bus.inst = inst;
        fetch_bus.pc   = pc;
        fs_valid       = 1'b1;
        #50;
        while (!ds_allowin) begin
            if (n == timeout_cycles) fail_run("timeout: ds_allowin never went high");
            n++;
            tick();
            #50;
        end
        tick();
        fs_valid = 1'b0;
    endtask

    task automatic wait_es_valid();
        int n;
        n = 0;
        #50;
        while (!es_valid) begin
            if (n == timeout_cycles) fail_run("timeout: es_valid never went high");
            n++;
            tick();
            #50;
        end
    endtask

    // flags are {gr_we, res_from_mem, mem_we}
    task automatic check_alu(input string name, input logic [31:0] inst, input alu_op_e op,
                             input logic imm_sel, input logic pc_sel, input logic [31:0] imm,
                             input logic [2:0] flags);
        exec_bus_t exp;
        exp.pc           = next_pc;
        exp.alu_op       = op;
        exp.alu_src1     = pc_sel ? next_pc : reg_val(inst[9:5]);
        exp.st_data      = flags[0] ? reg_val(inst[4:0]) : reg_val(inst[14:10]);
        exp.alu_src2     = imm_sel ? imm : exp.st_data;
        exp.res_from_mem = flags[1];
        exp.mem_we       = flags[0];
        exp.dest         = inst[4:0];
        exp.gr_we        = flags[2];
        send(inst, next_pc);
        wait_es_valid();
        check_exec(name, exec_bus, exp);
        tick();
        next_pc = next_pc + 32'd4;
    endtask

    task automatic test_alu_decode();
        logic [31:0] value;
        logic [31:0] inst;
        logic [4:0]  codes3 [11];
        alu_op_e     ops3 [11];
        logic [3:0]  codes_i [6];
        alu_op_e     ops_i [6];
        logic [4:0]  codes_sh [3];
        alu_op_e     ops_sh [3];
        codes3   = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
        ops3     = '{alu_add, alu_sub, alu_slt, alu_sltu, alu_nor, alu_and, alu_or, alu_xor,
                     alu_sll, alu_srl, alu_sra};
        codes_i  = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
        ops_i    = '{alu_slt, alu_sltu, alu_add, alu_and, alu_or, alu_xor};
        codes_sh = '{5'h01, 5'h09, 5'h11};
        ops_sh   = '{alu_sll, alu_srl, alu_sra};
        for (int r = 1; r < 32; r++) begin
            next_rand(value);
            write_reg(r[4:0], value);
        end
        for (int i = 0; i < 11; i++) begin
            inst = {6'h00, 4'h0, 2'h1, codes3[i], 5'd5, 5'd4, 5'd6};
            check_alu("alu 3r", inst, ops3[i], 1'b0, 1'b0, 32'h0, 3'b100);
        end
        for (int i = 0; i < 6; i++) begin
            inst = {6'h00, codes_i[i], 12'h8a5, 5'd4, 5'd6};
            // logic immediates are zero extended
            value = (codes_i[i] >= 4'hd) ? {20'h0, inst[21:10]} : sext12(inst);
            check_alu("alu imm", inst, ops_i[i], 1'b1, 1'b0, value, 3'b100);
        end
        for (int i = 0; i < 3; i++) begin
            inst = {6'h00, 4'h1, 2'h0, codes_sh[i], 5'd7, 5'd4, 5'd6};
            check_alu("alu shift", inst, ops_sh[i], 1'b1, 1'b0, sext12(inst), 3'b100);
        end
        inst = {6'h05, 1'b0, 20'habcde, 5'd6};
        check_alu("lu12i.w", inst, alu_lui, 1'b1, 1'b0, {20'habcde, 12'h0}, 3'b100);
        inst = {6'h07, 1'b0, 20'h12345, 5'd6};
        check_alu("pcaddu12i", inst, alu_add, 1'b1, 1'b1, {20'h12345, 12'h0}, 3'b100);
        inst = {6'h0a, 4'h2, 12'hff8, 5'd4, 5'd6};
        check_alu("ld.w", inst, alu_add, 1'b1, 1'b0, sext12(inst), 3'b110);
        inst = {6'h0a, 4'h6, 12'h010, 5'd4, 5'd6};
        check_alu("st.w", inst, alu_add, 1'b1, 1'b0, sext12(inst), 3'b001);
    endtask

    task automatic check_add(input string name, input logic [4:0] rj, input logic [4:0] rk,
                             input logic [31:0] src1, input logic [31:0] src2);
        exec_bus_t exp;
        exp = '{pc: next_pc, alu_op: alu_add, alu_src1: src1, alu_src2: src2, st_data: src2,
                res_from_mem: 1'b0, mem_we: 1'b0, dest: 5'd3, gr_we: 1'b1};
        send({6'h00, 4'h0, 2'h1, 5'h00, rk, rj, 5'd3}, next_pc);
        wait_es_valid();
        check_exec(name, exec_bus, exp);
        tick();
        next_pc = next_pc + 32'd4;
    endtask

    task automatic test_forwarding();
        set_fwd(5'd5, 32'haaaa_0001, 5'd5, 32'hbbbb_0002, 5'd5, 32'hcccc_0003);
        check_add("fwd execute", 5'd5, 5'd6, 32'haaaa_0001, reg_val(5'd6));
        set_fwd(5'd0, 32'haaaa_0001, 5'd5, 32'hbbbb_0002, 5'd5, 32'hcccc_0003);
        check_add("fwd memory", 5'd5, 5'd6, 32'hbbbb_0002, reg_val(5'd6));
        set_fwd(5'd0, 32'h0, 5'd6, 32'hbbbb_0002, 5'd5, 32'hcccc_0003);
        check_add("fwd write-back", 5'd5, 5'd6, 32'hcccc_0003, 32'hbbbb_0002);
        set_fwd(5'd0, 32'h1111_1111, 5'd0, 32'h2222_2222, 5'd0, 32'h3333_3333);
        check_add("fwd none", 5'd5, 5'd6, reg_val(5'd5), reg_val(5'd6));
        check_add("fwd r0", 5'd0, 5'd6, 32'h0, reg_val(5'd6));
        set_fwd(5'd0, 32'h0, 5'd0, 32'h0, 5'd0, 32'h0);
    endtask

    task automatic test_load_use();
        exec_bus_t exp;
        es_fwd = '{dest: 5'd5, value: 32'h5a5a_1234, from_mem: 1'b1};
        send({6'h00, 4'h0, 2'h1, 5'h00, 5'd6, 5'd5, 5'd3}, next_pc);
        for (int i = 0; i < 3; i++) begin
            #50;
            check_bit("es_valid in load-use", es_valid, 1'b0);
            check_bit("ds_allowin in load-use", ds_allowin, 1'b0);
            tick();
        end
        es_fwd = '{dest: 5'd0, value: 32'h0, from_mem: 1'b0};
        ms_fwd = '{dest: 5'd5, value: 32'h5a5a_1234, from_mem: 1'b0};
        // load result now comes from the memory stage
        exp = '{pc: next_pc, alu_op: alu_add, alu_src1: 32'h5a5a_1234,
                alu_src2: reg_val(5'd6), st_data: reg_val(5'd6), res_from_mem: 1'b0,
                mem_we: 1'b0, dest: 5'd3, gr_we: 1'b1};
        wait_es_valid();
        check_exec("load-use issue", exec_bus, exp);
        tick();
        ms_fwd = '{dest: 5'd0, value: 32'h0, from_mem: 1'b0};
        next_pc = next_pc + 32'd4;
    endtask

    task automatic branch_case(input string name, input logic [31:0] inst,
                               input logic taken, input logic [31:0] target,
                               input logic link);
        logic [31:0] pc;
        branch_t     exp_br;
        exec_bus_t   exp_link;
        exec_bus_t   exp_follow;
        pc = next_pc;
        exp_br.taken  = taken;
        exp_br.target = target;
        // link value pc + 4 goes to r1 through the ALU
        exp_link = '{pc: pc, alu_op: alu_add, alu_src1: pc, alu_src2: 32'd4,
                     st_data: reg_val(inst[14:10]), res_from_mem: 1'b0, mem_we: 1'b0,
                     dest: 5'd1, gr_we: 1'b1};
        exp_follow = '{pc: pc + 32'd4, alu_op: alu_add, alu_src1: 32'h0, alu_src2: 32'h1,
                       st_data: reg_val(5'd1), res_from_mem: 1'b0, mem_we: 1'b0,
                       dest: 5'd7, gr_we: 1'b1};
        send(inst, pc);
        // follower sits behind the branch in fetch
        fetch_bus.inst = {6'h00, 4'ha, 12'h001, 5'd0, 5'd7};
        fetch_bus.pc   = pc + 32'd4;
        fs_valid       = 1'b1;
        wait_es_valid();
        check_branch(name, br, exp_br);
        if (link) begin
            check_exec(name, exec_bus, exp_link);
        end
        tick();
        fs_valid = 1'b0;
        #50;
        check_bit("follower valid", es_valid, !taken);
        if (!taken) begin
            check_exec("follower", exec_bus, exp_follow);
        end
        tick();
        #50;
        check_bit("stage empty after branch", es_valid, 1'b0);
        tick();
        next_pc = next_pc + 32'd16;
    endtask

    task automatic test_branches();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] pc_offs;
        logic        t;
        next_rand(a);
        next_rand(b);
        write_reg(5'd10, a);
        write_reg(5'd11, b);
        write_reg(5'd12, a);
        pc_offs = {{14{1'b1}}, 16'hfff0, 2'b00};
        for (int p = 0; p < 2; p++) begin
            x = a;
            y = (p == 0) ? b : a;
            for (int k = 0; k < 6; k++) begin
                case (k)
                    0: t = (x == y);
                    1: t = (x != y);
                    2: t = ($signed(x) < $signed(y));
                    3: t = ($signed(x) >= $signed(y));
                    4: t = (x < y);
                    default: t = (x >= y);
                endcase
                branch_case("conditional branch", {6'h16 + 6'(k), 16'hfff0, 5'd10,
                            (p == 0) ? 5'd11 : 5'd12}, t, next_pc + pc_offs, 1'b0);
            end
        end
        branch_case("b", {6'h14, 16'h0100, 10'h3ff}, 1'b1,
                    next_pc + {{4{1'b1}}, 26'h3ff_0100, 2'b00}, 1'b0);
        branch_case("bl", {6'h15, 16'h0040, 10'h000}, 1'b1, next_pc + 32'h0000_0100, 1'b1);
        branch_case("jirl", {6'h13, 16'h0008, 5'd10, 5'd1}, 1'b1, a + 32'h0000_0020, 1'b1);
    endtask

    task automatic test_back_pressure();
        exec_bus_t exp;
        exp = '{pc: next_pc, alu_op: alu_add, alu_src1: reg_val(5'd4),
                alu_src2: 32'h0000_0123, st_data: reg_val(5'd3), res_from_mem: 1'b0,
                mem_we: 1'b0, dest: 5'd7, gr_we: 1'b1};
        es_allowin = 1'b0;
        send({6'h00, 4'ha, 12'h123, 5'd4, 5'd7}, next_pc);
        wait_es_valid();
        check_exec("exec_bus under back-pressure", exec_bus, exp);
        for (int i = 0; i < 3; i++) begin
            tick();
            #50;
            check_bit("es_valid held", es_valid, 1'b1);
            check_bit("ds_allowin held", ds_allowin, 1'b0);
            check_exec("exec_bus held", exec_bus, exp);
        end
        tick();
        es_allowin = 1'b1;
        #50;
        check_bit("es_valid on release", es_valid, 1'b1);
        tick();
        #50;
        check_bit("single issue", es_valid, 1'b0);
        tick();
        next_pc = next_pc + 32'd4;
    endtask

    task automatic test_flush();
        es_allowin = 1'b0;
        send({6'h00, 4'ha, 12'h456, 5'd4, 5'd7}, next_pc);
        wait_es_valid();
        tick();
        flush = 1'b1;
        #50;
        check_bit("es_valid under flush", es_valid, 1'b0);
        tick();
        flush      = 1'b0;
        es_allowin = 1'b1;
        #50;
        check_bit("es_valid after flush", es_valid, 1'b0);
        check_bit("ds_allowin after flush", ds_allowin, 1'b1);
        tick();
        next_pc = next_pc + 32'd4;
        check_alu("after flush", {6'h00, 4'ha, 12'h00c, 5'd4, 5'd7}, alu_add, 1'b1, 1'b0,
                  32'h0000_000c, 3'b100);
    endtask

    initial begin
        reset      = 1'b1;
        fs_valid   = 1'b0;
        fetch_bus  = '0;
        es_allowin = 1'b1;
        rf_wr      = '0;
        es_fwd     = '0;
        ms_fwd     = '0;
        ws_fwd     = '0;
        flush      = 1'b0;
        lfsr_state = 32'd67875;
        next_pc    = 32'h1c00_0000;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;
        #50;
        check_bit("es_valid after reset", es_valid, 1'b0);
        check_bit("br.taken after reset", br.taken, 1'b0);
        check_bit("ds_allowin after reset", ds_allowin, 1'b1);
        tick();
        test_alu_decode();
        test_forwarding();
        test_load_use();
        test_branches();
        test_back_pressure();
        test_flush();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* id_stage.f */
decode_pkg.sv
inst_decoder.sv
regfile.sv
operand_bypass.sv
branch_unit.sv
decode_stage.sv
decode_assert.sv
tb_decode_stage.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module tb_decode_stage \
    -f id_stage.f -Mdir obj_dir -o sim_decode_stage \
    && ./obj_dir/sim_decode_stage > sim.log 2>&1
cat sim.log
grep -q "\*\*\* PASSED \*\*\*" sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
